// File: hdl/debugPkg.sv
package debugPkg;

    // ==============================
    // byte types
    // ==============================

    // host to design, one byte per serial frame
    typedef logic [7:0] cmdByte_t;

    // design to host, length byte or payload byte
    typedef logic [7:0] rspByte_t;

    // ==============================
    // command and reply codes
    // ==============================

    // silent, filtered before the inbound FIFO
    localparam cmdByte_t CmdNop = 8'h00;
    // led[0] control, echoed back
    localparam cmdByte_t CmdLedOff = 8'h80;
    localparam cmdByte_t CmdLedOn = 8'h81;
    // two pattern words, four bytes of reply
    localparam cmdByte_t CmdReadPattern = 8'h82;

    // reply for anything not decoded
    localparam rspByte_t RspError = 8'hEE;

    // ==============================
    // test pattern
    // ==============================

    // stands in for memory contents at a word address
    // upper address byte padded with 0x55, xor inverted address
    function automatic logic [15:0] patternWord(input logic [15:0] addr);
        return {8'h55, addr[15:8]} ^ ~addr;
    endfunction

endpackage

// File: hdl/asyncFifo.sv
module asyncFifo #(
    parameter type payload_t = logic [7:0],
    parameter int FifoDepthLog2 = 3
) (
    input  logic     wclk,
    input  logic     rclk,
    input  logic     arstN,
    input  logic     push,
    input  payload_t pushData,
    input  logic     pop,
    output logic     pushOk,
    output payload_t popData,
    output logic     popOk
);

    localparam int Depth = 1 << FifoDepthLog2;
    // one extra bit tells full from empty
    localparam int PtrW = FifoDepthLog2 + 1;

    payload_t mem [Depth];

    // write domain
    logic [PtrW-1:0] wBin;
    logic [PtrW-1:0] wBinNext;
    logic [PtrW-1:0] wGray;
    logic [PtrW-1:0] rGraySync1;
    logic [PtrW-1:0] rGraySync2;
    logic            wEn;

    // read domain
    logic [PtrW-1:0] rBin;
    logic [PtrW-1:0] rBinNext;
    logic [PtrW-1:0] rGray;
    logic [PtrW-1:0] wGraySync1;
    logic [PtrW-1:0] wGraySync2;
    logic            rEn;

    // pointer views across domains, only for the checks below
    logic [PtrW-1:0] wSideRBin;
    logic [PtrW-1:0] rSideWBin;

    function automatic logic [PtrW-1:0] grayToBin(input logic [PtrW-1:0] g);
        logic [PtrW-1:0] b;
        b[PtrW-1] = g[PtrW-1];
        for (int i = PtrW - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // ==============================
    // write side
    // ==============================

    // full when the top two gray bits differ and the rest match
    assign pushOk = wGray != {~rGraySync2[PtrW-1 -: 2], rGraySync2[PtrW-3:0]};
    assign wEn = push && pushOk;
    assign wBinNext = wBin + 1'b1;

    always_ff @(posedge wclk or negedge arstN) begin
        if (!arstN) begin
            wBin <= '0;
            wGray <= '0;
        end else if (wEn) begin
            wBin <= wBinNext;
            wGray <= wBinNext ^ (wBinNext >> 1);
        end
    end

    always_ff @(posedge wclk) begin
        if (wEn) begin
            mem[wBin[FifoDepthLog2-1:0]] <= pushData;
        end
    end

    // read pointer into the write clock, two flops
    always_ff @(posedge wclk or negedge arstN) begin
        if (!arstN) begin
            rGraySync1 <= '0;
            rGraySync2 <= '0;
        end else begin
            rGraySync1 <= rGray;
            rGraySync2 <= rGraySync1;
        end
    end

    // ==============================
    // read side
    // ==============================

    assign popOk = rGray != wGraySync2;
    assign rEn = pop && popOk;
    assign rBinNext = rBin + 1'b1;
    // head entry, valid while popOk
    assign popData = mem[rBin[FifoDepthLog2-1:0]];

    always_ff @(posedge rclk or negedge arstN) begin
        if (!arstN) begin
            rBin <= '0;
            rGray <= '0;
        end else if (rEn) begin
            rBin <= rBinNext;
            rGray <= rBinNext ^ (rBinNext >> 1);
        end
    end

    always_ff @(posedge rclk or negedge arstN) begin
        if (!arstN) begin
            wGraySync1 <= '0;
            wGraySync2 <= '0;
        end else begin
            wGraySync1 <= wGray;
            wGraySync2 <= wGraySync1;
        end
    end

    // occupancy seen from either side never goes past capacity
    assign wSideRBin = grayToBin(rGraySync2);
    assign rSideWBin = grayToBin(wGraySync2);

    // an accepted push while full would push the distance past Depth
    assert property (@(posedge wclk) disable iff (!arstN)
        PtrW'(wBin - wSideRBin) <= Depth);

    // an accepted pop while empty would wrap the distance negative
    assert property (@(posedge rclk) disable iff (!arstN)
        PtrW'(rSideWBin - rBin) <= Depth);

endmodule

// File: hdl/serialLink.sv
module serialLink (
    input  logic               debugClk,
    input  logic               arstN,
    input  logic               debugCs,
    input  logic               debugDi,
    input  logic               pushOk,
    input  debugPkg::rspByte_t popData,
    input  logic               popOk,
    output logic               debugDo,
    output logic               push,
    output debugPkg::cmdByte_t pushData,
    output logic               pop,
    output logic               overflowToggle
);

    // bit position inside the current 8-bit frame
    logic [2:0]         bitCnt;
    logic [6:0]         inShift;
    debugPkg::cmdByte_t inByte;
    debugPkg::rspByte_t outShift;
    // outShift holds a fetched byte that has not started shifting
    logic               outHeld;
    logic               frameEnd;

    assign frameEnd = debugCs && (bitCnt == 3'd7);
    // complete byte on the eighth bit
    assign inByte = {inShift, debugDi};

    // fetch for the next frame on the last bit of this one
    // idle with chip select low: prefetch once so the first frame is ready
    assign pop = popOk && (frameEnd || (!debugCs && !outHeld));

    // ==============================
    // command input
    // ==============================

    // counters held at zero while deselected
    always_ff @(posedge debugClk or negedge arstN) begin
        if (!arstN) begin
            bitCnt <= '0;
            push <= 1'b0;
        end else if (!debugCs) begin
            bitCnt <= '0;
            push <= 1'b0;
        end else begin
            bitCnt <= bitCnt + 3'd1;
            // no-op bytes never reach the FIFO
            push <= frameEnd && (inByte != debugPkg::CmdNop);
        end
    end

    // msb first
    always_ff @(posedge debugClk) begin
        if (debugCs) begin
            inShift <= {inShift[5:0], debugDi};
        end
        if (frameEnd) begin
            pushData <= inByte;
        end
    end

    // dropped command, flip the level for the clk side
    always_ff @(posedge debugClk or negedge arstN) begin
        if (!arstN) begin
            overflowToggle <= 1'b0;
        end else if (push && !pushOk) begin
            overflowToggle <= ~overflowToggle;
        end
    end

    // ==============================
    // response output
    // ==============================

    // empty FIFO at a boundary sends a zero frame
    always_ff @(posedge debugClk or negedge arstN) begin
        if (!arstN) begin
            outShift <= '0;
            outHeld <= 1'b0;
        end else if (debugCs) begin
            if (frameEnd) begin
                outShift <= popOk ? popData : '0;
                outHeld <= popOk;
            end else begin
                outShift <= {outShift[6:0], 1'b0};
                outHeld <= 1'b0;
            end
        end else if (!outHeld) begin
            outShift <= popOk ? popData : '0;
            outHeld <= popOk;
        end
    end

    // launch on the falling edge, host samples on the rising edge
    always_ff @(negedge debugClk or negedge arstN) begin
        if (!arstN) begin
            debugDo <= 1'b0;
        end else begin
            debugDo <= debugCs ? outShift[7] : 1'b0;
        end
    end

endmodule

// File: hdl/msgFramer.sv
module msgFramer (
    input  logic               clk,
    input  logic               arstN,
    input  debugPkg::rspByte_t msgLen,
    input  debugPkg::rspByte_t msgByte,
    input  logic               pushOk,
    output logic               msgNext,
    output logic               push,
    output debugPkg::rspByte_t pushData
);

    // length byte already in the FIFO
    logic               lenSent;
    // data bytes still to go
    debugPkg::rspByte_t remain;
    logic               accepted;

    // ==============================
    // push side
    // ==============================

    // push held while a message is pending, stalls on back-pressure
    assign push = msgLen != '0;
    // length first, then the bytes the handler presents
    assign pushData = lenSent ? msgByte : msgLen;
    assign accepted = push && pushOk;
    // only data bytes advance the handler
    assign msgNext = accepted && lenSent;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lenSent <= 1'b0;
            remain <= '0;
        end else if (accepted) begin
            if (!lenSent) begin
                lenSent <= 1'b1;
                remain <= msgLen;
            end else begin
                remain <= remain - 8'd1;
                // last byte, ready for the next length
                if (remain == 8'd1) begin
                    lenSent <= 1'b0;
                end
            end
        end
    end

    // ==============================
    // checks
    // ==============================

    // handler keeps the message up until its last byte is taken
    assert property (@(posedge clk) disable iff (!arstN)
        lenSent |-> msgLen != '0);

    // and drops it right after
    assert property (@(posedge clk) disable iff (!arstN)
        (msgNext && remain == 8'd1) |=> msgLen == '0);

endmodule

// File: hdl/cmdHandler.sv
module cmdHandler (
    input  logic               clk,
    input  logic               arstN,
    input  debugPkg::cmdByte_t cmd,
    input  logic               cmdOk,
    input  logic               overflowToggle,
    input  logic               msgNext,
    output logic               cmdPop,
    output debugPkg::rspByte_t msgLen,
    output debugPkg::rspByte_t msgByte,
    output logic [3:0]         led
);

    // reply bytes, sent in index order
    debugPkg::rspByte_t rspBuf [4];
    logic [1:0]         rdIdx;
    // word address of the next pattern read
    logic [15:0]        patAddr;
    logic [15:0]        word0;
    logic [15:0]        word1;
    logic               ledOn;
    logic               ovfSticky;
    logic [2:0]         ovfSync;

    // no new command until the reply is out
    assign cmdPop = cmdOk && (msgLen == '0);
    assign msgByte = rspBuf[rdIdx];
    assign word0 = debugPkg::patternWord(patAddr);
    assign word1 = debugPkg::patternWord(patAddr + 16'd1);
    // top two leds unused
    assign led = {2'b00, ovfSticky, ledOn};

    // ==============================
    // decode
    // ==============================

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ledOn <= 1'b0;
            patAddr <= '0;
            msgLen <= '0;
            rdIdx <= '0;
        end else if (cmdPop) begin
            rdIdx <= '0;
            case (cmd)
                debugPkg::CmdNop: begin
                    // nothing to send
                end
                debugPkg::CmdLedOff: begin
                    ledOn <= 1'b0;
                    msgLen <= 8'd1;
                end
                debugPkg::CmdLedOn: begin
                    ledOn <= 1'b1;
                    msgLen <= 8'd1;
                end
                debugPkg::CmdReadPattern: begin
                    patAddr <= patAddr + 16'd2;
                    msgLen <= 8'd4;
                end
                default: begin
                    msgLen <= 8'd1;
                end
            endcase
        end else if (msgNext) begin
            // step through the buffer, clear after the last byte
            rdIdx <= rdIdx + 2'd1;
            if (8'(rdIdx) == msgLen - 8'd1) begin
                msgLen <= '0;
            end
        end
    end

    // reply payload, high byte of each word first
    always_ff @(posedge clk) begin
        if (cmdPop) begin
            case (cmd)
                debugPkg::CmdLedOff, debugPkg::CmdLedOn: begin
                    rspBuf[0] <= cmd;
                end
                debugPkg::CmdReadPattern: begin
                    rspBuf[0] <= word0[15:8];
                    rspBuf[1] <= word0[7:0];
                    rspBuf[2] <= word1[15:8];
                    rspBuf[3] <= word1[7:0];
                end
                default: begin
                    rspBuf[0] <= debugPkg::RspError;
                end
            endcase
        end
    end

    // ==============================
    // overflow flag
    // ==============================

    // toggle from the debug clock, two flops then edge detect
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ovfSync <= '0;
            ovfSticky <= 1'b0;
        end else begin
            ovfSync <= {ovfSync[1:0], overflowToggle};
            if (ovfSync[2] != ovfSync[1]) begin
                ovfSticky <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/debugTop.sv
module debugTop #(
    parameter int FifoDepthLog2 = 3
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       debugClk,
    input  logic       debugCs,
    input  logic       debugDi,
    output logic       debugDo,
    output logic [3:0] led
);

    // inbound, debug clock to clk
    logic               cmdPush;
    debugPkg::cmdByte_t cmdPushData;
    logic               cmdPushOk;
    logic               cmdPop;
    debugPkg::cmdByte_t cmd;
    logic               cmdOk;

    // outbound, clk to debug clock
    logic               rspPush;
    debugPkg::rspByte_t rspPushData;
    logic               rspPushOk;
    logic               rspPop;
    debugPkg::rspByte_t rspPopData;
    logic               rspPopOk;

    // handler to framer
    debugPkg::rspByte_t msgLen;
    debugPkg::rspByte_t msgByte;
    logic               msgNext;
    logic               overflowToggle;

    // ==============================
    // FIFOs
    // ==============================

    asyncFifo #(
        .payload_t    (debugPkg::cmdByte_t),
        .FifoDepthLog2(FifoDepthLog2)
    ) cmdFifoInst (
        .wclk    (debugClk),
        .rclk    (clk),
        .arstN   (arstN),
        .push    (cmdPush),
        .pushData(cmdPushData),
        .pop     (cmdPop),
        .pushOk  (cmdPushOk),
        .popData (cmd),
        .popOk   (cmdOk)
    );

    asyncFifo #(
        .payload_t    (debugPkg::rspByte_t),
        .FifoDepthLog2(FifoDepthLog2)
    ) rspFifoInst (
        .wclk    (clk),
        .rclk    (debugClk),
        .arstN   (arstN),
        .push    (rspPush),
        .pushData(rspPushData),
        .pop     (rspPop),
        .pushOk  (rspPushOk),
        .popData (rspPopData),
        .popOk   (rspPopOk)
    );

    // ==============================
    // link, framer, handler
    // ==============================

    serialLink linkInst (
        .debugClk      (debugClk),
        .arstN         (arstN),
        .debugCs       (debugCs),
        .debugDi       (debugDi),
        .pushOk        (cmdPushOk),
        .popData       (rspPopData),
        .popOk         (rspPopOk),
        .debugDo       (debugDo),
        .push          (cmdPush),
        .pushData      (cmdPushData),
        .pop           (rspPop),
        .overflowToggle(overflowToggle)
    );

    msgFramer framerInst (
        .clk     (clk),
        .arstN   (arstN),
        .msgLen  (msgLen),
        .msgByte (msgByte),
        .pushOk  (rspPushOk),
        .msgNext (msgNext),
        .push    (rspPush),
        .pushData(rspPushData)
    );

    cmdHandler handlerInst (
        .clk           (clk),
        .arstN         (arstN),
        .cmd           (cmd),
        .cmdOk         (cmdOk),
        .overflowToggle(overflowToggle),
        .msgNext       (msgNext),
        .cmdPop        (cmdPop),
        .msgLen        (msgLen),
        .msgByte       (msgByte),
        .led           (led)
    );

endmodule

// File: verification/debugTb.sv
module debugTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumEntries = 7;
    localparam int BurstLen = 20;
    // idle frames before a read gives up
    localparam int IdleLimit = 64;
    // command frame, idle search, length and four data frames
    localparam int FramesPerEntry = 1 + IdleLimit + 5;
    localparam int TotalFrames = 16 + NumEntries * FramesPerEntry
                                 + BurstLen * 6 + IdleLimit + 100;
    // a frame is 8 debug cycles of 70 ns, counted here in 20 ns clk cycles
    localparam int CycleLimit = TotalFrames * 28;

    logic       clk;
    logic       debugClk;
    logic       arstN;
    logic       debugCs;
    logic       debugDi;
    logic       debugDo;
    logic [3:0] led;

    // stimulus table
    debugPkg::cmdByte_t tblCmd [NumEntries];
    logic               tblLed0 [NumEntries];
    debugPkg::rspByte_t tblLen [NumEntries];
    debugPkg::rspByte_t tblRsp [NumEntries][4];

    // last message seen by the host
    debugPkg::rspByte_t rxLen;
    debugPkg::rspByte_t rxData [4];
    // every frame of the overflow burst and its drain
    debugPkg::rspByte_t rxQ [$];
    debugPkg::cmdByte_t burstCmd [BurstLen];

    // word address the handler should read next
    logic [15:0] modelAddr;
    int          errCount;
    int          testCount;
    int          cycleCount;

    debugTop #(
        .FifoDepthLog2(3)
    ) debugTop_inst (
        .clk     (clk),
        .arstN   (arstN),
        .debugClk(debugClk),
        .debugCs (debugCs),
        .debugDi (debugDi),
        .debugDo (debugDo),
        .led     (led)
    );

    // ==============================
    // clocks and timeout
    // ==============================

    always #10 clk = ~clk;
    // 70 ns, unrelated to clk
    always #35 debugClk = ~debugClk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: run went past %0d clk cycles", CycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    // ==============================
    // host side and checks
    // ==============================

    // one full-duplex frame, msb first, starts and ends 2 ns after a rising edge
    task automatic shiftFrame(input debugPkg::cmdByte_t tx, output debugPkg::rspByte_t rx);
        for (int i = 7; i >= 0; i--) begin
            debugDi = tx[i];
            @(posedge debugClk);
            rx[i] = debugDo;
            #2;
        end
    endtask

    task automatic checkByte(input string name, input debugPkg::rspByte_t expected,
                             input debugPkg::rspByte_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s expected 0x%02h got 0x%02h",
                     $time, name, expected, actual);
            errCount++;
        end
    endtask

    task automatic checkLed(input logic [3:0] expected, input logic [3:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: led expected %b got %b", $time, expected, actual);
            errCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCount++;
        $display("test %0d %s: %s", testCount, name, (errCount == errBefore) ? "ok" : "FAILED");
    endtask

    // idle frames until a length shows, then that many data frames
    task automatic readResponse();
        debugPkg::rspByte_t rx;
        int                 idle;
        idle = 0;
        shiftFrame(debugPkg::CmdNop, rx);
        while (rx == 8'h00 && idle < IdleLimit - 1) begin
            idle++;
            shiftFrame(debugPkg::CmdNop, rx);
        end
        rxLen = rx;
        if (rx == 8'h00) begin
            $display("no response arrived within %0d frames", IdleLimit);
            errCount++;
        end
        for (int i = 0; i < rxLen && i < 4; i++) begin
            shiftFrame(debugPkg::CmdNop, rxData[i]);
        end
    endtask

    task automatic buildTable();
        logic [15:0] w0;
        logic [15:0] w1;
        modelAddr = 16'd0;
        foreach (tblRsp[e, i]) begin
            tblRsp[e][i] = 8'h00;
        end
        tblCmd[0] = debugPkg::CmdLedOn;
        tblLed0[0] = 1'b1;
        tblLen[0] = 8'd1;
        tblRsp[0][0] = debugPkg::CmdLedOn;
        tblCmd[1] = debugPkg::CmdLedOff;
        tblLed0[1] = 1'b0;
        tblLen[1] = 8'd1;
        tblRsp[1][0] = debugPkg::CmdLedOff;
        // three reads, address steps by two
        for (int e = 2; e < 5; e++) begin
            w0 = debugPkg::patternWord(modelAddr);
            w1 = debugPkg::patternWord(modelAddr + 16'd1);
            tblCmd[e] = debugPkg::CmdReadPattern;
            tblLed0[e] = 1'b0;
            tblLen[e] = 8'd4;
            tblRsp[e][0] = w0[15:8];
            tblRsp[e][1] = w0[7:0];
            tblRsp[e][2] = w1[15:8];
            tblRsp[e][3] = w1[7:0];
            modelAddr = modelAddr + 16'd2;
        end
        // silent
        tblCmd[5] = debugPkg::CmdNop;
        tblLed0[5] = 1'b0;
        tblLen[5] = 8'd0;
        // unknown code in 0x83..0xFF
        tblCmd[6] = 8'h83 + 8'($urandom % 125);
        tblLed0[6] = 1'b0;
        tblLen[6] = 8'd1;
        tblRsp[6][0] = debugPkg::RspError;
    endtask

    // walk the burst frames, each reply must belong to a later command than the last
    task automatic checkBurst();
        int          pos;
        int          next;
        int          count;
        int          len;
        logic [15:0] w0;
        logic [15:0] w1;
        pos = 0;
        next = 0;
        count = 0;
        while (pos < rxQ.size()) begin
            if (rxQ[pos] == 8'h00) begin
                pos++;
            end else begin
                len = rxQ[pos];
                // dropped commands leave no reply
                while (next < BurstLen
                       && ((burstCmd[next] == debugPkg::CmdReadPattern) != (len == 4))) begin
                    next++;
                end
                if (next >= BurstLen || pos + len >= rxQ.size()) begin
                    $display("burst reply %0d of length %0d matches no command sent", count, len);
                    errCount++;
                    pos = rxQ.size();
                end else begin
                    if (len == 4) begin
                        w0 = debugPkg::patternWord(modelAddr);
                        w1 = debugPkg::patternWord(modelAddr + 16'd1);
                        checkByte("burst pattern byte 0", w0[15:8], rxQ[pos+1]);
                        checkByte("burst pattern byte 1", w0[7:0], rxQ[pos+2]);
                        checkByte("burst pattern byte 2", w1[15:8], rxQ[pos+3]);
                        checkByte("burst pattern byte 3", w1[7:0], rxQ[pos+4]);
                        modelAddr = modelAddr + 16'd2;
                    end else begin
                        checkByte("burst echo length", 8'd1, rxQ[pos]);
                        checkByte("burst echo", burstCmd[next], rxQ[pos+1]);
                    end
                    count++;
                    next++;
                    pos = pos + len + 1;
                end
            end
        end
        $display("burst: %0d of %0d commands answered", count, BurstLen);
        if (count >= BurstLen) begin
            $display("every burst command was answered, none was dropped");
            errCount++;
        end
    endtask

    // ==============================
    // main sequence
    // ==============================

    initial begin
        debugPkg::rspByte_t rx;
        int                 errBefore;
        int                 idle;
        clk = 1'b0;
        debugClk = 1'b0;
        arstN = 1'b0;
        debugCs = 1'b0;
        debugDi = 1'b0;
        errCount = 0;
        testCount = 0;
        cycleCount = 0;
        void'($urandom(80));
        buildTable();

        repeat (10) @(posedge clk);
        #2 arstN = 1'b1;
        // frames count from the rising chip select, kept high from here on
        @(posedge debugClk);
        #2 debugCs = 1'b1;

        errBefore = errCount;
        checkLed(4'b0000, led);
        for (int f = 0; f < 16; f++) begin
            shiftFrame(debugPkg::CmdNop, rx);
            checkByte("debugDo after reset", 8'h00, rx);
        end
        reportTest("reset state", errBefore);

        for (int e = 0; e < NumEntries; e++) begin
            errBefore = errCount;
            shiftFrame(tblCmd[e], rx);
            if (tblLen[e] == 8'd0) begin
                // nothing may come back
                for (int f = 0; f < 16; f++) begin
                    shiftFrame(debugPkg::CmdNop, rx);
                    checkByte("debugDo after no-op", 8'h00, rx);
                end
            end else begin
                readResponse();
                checkByte("response length", tblLen[e], rxLen);
                if (rxLen == tblLen[e]) begin
                    for (int i = 0; i < tblLen[e]; i++) begin
                        checkByte("response data", tblRsp[e][i], rxData[i]);
                    end
                end
            end
            checkLed({3'b000, tblLed0[e]}, led);
            reportTest($sformatf("command 0x%02h", tblCmd[e]), errBefore);
        end

        // mostly reads, outruns the outbound drain rate
        errBefore = errCount;
        rxQ.delete();
        for (int c = 0; c < BurstLen; c++) begin
            burstCmd[c] = (c % 4 == 3) ? debugPkg::CmdLedOn : debugPkg::CmdReadPattern;
            shiftFrame(burstCmd[c], rx);
            rxQ.push_back(rx);
        end
        idle = 0;
        while (idle < IdleLimit) begin
            shiftFrame(debugPkg::CmdNop, rx);
            rxQ.push_back(rx);
            idle = (rx == 8'h00) ? idle + 1 : 0;
        end
        checkBurst();
        checkLed(4'b0011, led);
        reportTest("burst overflow", errBefore);

        $display("%0d tests run, %0d errors", testCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
hdl/debugPkg.sv
hdl/asyncFifo.sv
hdl/serialLink.sv
hdl/msgFramer.sv
hdl/cmdHandler.sv
hdl/debugTop.sv
verification/debugTb.sv

// File: Bender.yml
package:
  name: debug_port

sources:
  # package first, then leaf modules, then the top level
  - hdl/debugPkg.sv
  - hdl/asyncFifo.sv
  - hdl/serialLink.sv
  - hdl/msgFramer.sv
  - hdl/cmdHandler.sv
  - hdl/debugTop.sv

  - target: simulation
    files:
      - verification/debugTb.sv
